/* tcp_ack_top.f */
+incdir+common
common/tcp_ack_pkg.sv
src/tcp_rx_parser.sv
tcp_ack/tcp_ack_ctrl.sv
tcp_ack/tcp_ack_tx.sv
src/tcp_ack_top.sv
verification/tcp_ack_sva.sv
verification/tcp_ack_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the tcp ack testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tcp_ack_tb -f tcp_ack_top.f -o tcp_ack_sim

./obj_dir/tcp_ack_sim > sim.log 2>&1 || true
cat sim.log

# the log decides, the simulator status alone is not enough
if grep -q "^TEST PASS$" sim.log; then
  exit 0
else
  exit 1
fi

/* verification/tcp_ack_tb.sv */
`include "tcp_ack_config.svh"

module tcp_ack_tb;

  import tcp_ack_pkg::*;

  localparam int timeout   = `TCP_ACK_TIMEOUT;
  localparam int force_cnt = `TCP_ACK_FORCE_PKTS;
  localparam int hdr_bytes = `TCP_HDR_BYTES;
  localparam int max_pld   = 40;
  localparam int seg_cyc   = hdr_bytes + max_pld + 4; // bytes plus idle gap
  localparam int wd_cycles = 2 * (14 * seg_cyc + 7 * (timeout + 40)) + 20;

  logic clk = 1'b0;
  logic rst, rx_val, rx_sof, rx_eof, init, tx_val, tx_sof, tx_eof;
  logic [7:0] rx_byte, tx_byte;
  logic [15:0] rx_len;
  tcb_t tcb, tcb_d1;
  tcp_stat_t status;
  tcp_num_t loc_ack, ref_ack, ack_d1, cur_end, pend_end;
  logic pend_val;
  logic [159:0] exp_hdr, got;
  int seed = 32'he6a7;
  int errs = 0, hdr_cnt = 0, sof_cnt = 0, cyc = 0, sof_cyc = 0, eof_cyc = 0;

  tcp_ack_top dut (.*);

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // only a nonzero forward distance below 2^31 moves the ack
  function automatic tcp_num_t next_ack(input tcp_num_t cur, input tcp_num_t seg_end);
    tcp_num_t d;
    d = seg_end - cur;
    return ((d != 32'd0) && !d[31]) ? seg_end : cur;
  endfunction

  // pure ack header with offset 5 and flags 0x010
  function automatic logic [159:0] hdr_image(input tcb_t t, input tcp_num_t ack);
    return {t.loc_port, t.rem_port, t.loc_seq, ack, 16'h5010, t.win, 32'd0};
  endfunction

  // ack model with meta one cycle after eof and the ack one cycle later
  always @(posedge clk) begin
    if (rst) begin
      pend_val <= 1'b0;
      ref_ack  <= '0;
    end else begin
      pend_val <= rx_val && rx_eof;
      pend_end <= cur_end;
      if (init) ref_ack <= tcb.loc_ack;
      else if (pend_val) ref_ack <= next_ack(ref_ack, pend_end);
    end
  end

  ////////////////////////////////////////////////////////////
  // header monitor
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [159:0] full;
    full = {got[151:0], tx_byte};
    ack_d1 <= ref_ack;  // transmitter snapshots one edge before sof shows
    tcb_d1 <= tcb;
    cyc    <= cyc + 1;
    if (tx_val) begin
      got <= full;
      if (tx_sof) begin
        exp_hdr <= hdr_image(tcb_d1, ack_d1);
        sof_cyc <= cyc;
        sof_cnt <= sof_cnt + 1;
      end
      if (tx_eof) begin
        hdr_cnt <= hdr_cnt + 1;
        assert (full == exp_hdr) else begin
          $display("Mismatch at %0t: header %h, expected %h", $time, full, exp_hdr);
          errs++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic send_seg(input tcp_num_t seq, input int pld);
    int total;
    logic [7:0] b;
    logic [159:0] h;
    total = hdr_bytes + pld;
    h = {16'($random(seed)), 16'($random(seed)), seq, 32'($random(seed)),
         16'h5010, 16'hffff, 32'd0};
    for (int i = 0; i < total; i++) begin
      b = (i < hdr_bytes) ? h[159 - 8 * i -: 8] : 8'($random(seed));
      @(posedge clk);
      rx_val  <= 1'b1;
      rx_byte <= b;
      rx_sof  <= (i == 0);
      rx_eof  <= (i == total - 1);
      rx_len  <= 16'(total);
      cur_end <= seq + 32'(pld);
      if (i == total - 1) eof_cyc = cyc;
    end
    @(posedge clk);
    rx_val <= 1'b0;
    rx_sof <= 1'b0;
    rx_eof <= 1'b0;
    repeat (3) @(posedge clk); // lets the ack settle before the next segment
  endtask

  // at least one payload byte so every new segment moves the ack
  function automatic int rand_pld();
    return 1 + int'($unsigned($random(seed)) % max_pld);
  endfunction

  task automatic wait_headers(input int target, input int limit);
    int n = 0;
    while ((hdr_cnt < target) && (n < limit)) begin
      @(posedge clk);
      n++;
    end
    assert (hdr_cnt >= target) else begin
      $display("no ack header arrived within %0d cycles at %0t", limit, $time);
      errs++;
    end
  endtask

  // peer has now seen our ack
  task automatic ack_seen();
    @(posedge clk);
    tcb.loc_ack <= ref_ack;
    repeat (2) @(posedge clk);
  endtask

  task automatic check_ack(input tcp_num_t want);
    assert ((loc_ack == ref_ack) && (ref_ack == want)) else begin
      $display("Mismatch at %0t: loc_ack %h, model %h, expected %h",
               $time, loc_ack, ref_ack, want);
      errs++;
    end
  endtask

  task automatic test_done(input int n, input string name);
    $display("test %0d %s done, headers %0d, errors %0d", n, name, hdr_cnt, errs);
  endtask

  ////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", wd_cycles);
    $display("TEST FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  initial begin
    int base, n, d;
    tcp_num_t a0;
    rst     = 1'b1;
    rx_val  = 1'b0;
    rx_sof  = 1'b0;
    rx_eof  = 1'b0;
    rx_byte = 8'd0;
    rx_len  = 16'd0;
    init    = 1'b0;
    status  = tcp_closed;
    cur_end = '0;
    got     = '0;
    tcb = '{loc_port: 16'h1f90, rem_port: 16'hc350, loc_seq: 32'($random(seed)),
            loc_ack: 32'($random(seed)), win: 16'h4000};
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    // test 1 loads the initial ack and a closed connection stays silent
    @(posedge clk) init <= 1'b1;
    @(posedge clk) init <= 1'b0;
    repeat (2) @(posedge clk);
    check_ack(tcb.loc_ack);
    send_seg(ref_ack, rand_pld());
    send_seg(ref_ack, rand_pld());
    repeat (timeout + 40) @(posedge clk);
    assert (hdr_cnt == 0) else begin
      $display("ack header sent while the connection was closed");
      errs++;
    end
    @(posedge clk) init <= 1'b1;
    @(posedge clk) begin
      init   <= 1'b0;
      status <= tcp_connected;
    end
    repeat (2) @(posedge clk);
    test_done(1, "init load");
    // test 2 forces an ack with segments counted only while data is unacked
    base = hdr_cnt;
    n = 0;
    while (n < force_cnt) begin
      if (ref_ack != tcb.loc_ack) n++;
      send_seg(ref_ack, rand_pld());
    end
    wait_headers(base + 1, 60);
    repeat (25) @(posedge clk);
    assert (hdr_cnt == base + 1) else begin
      $display("forced ack gave %0d headers instead of one", hdr_cnt - base);
      errs++;
    end
    ack_seen();
    test_done(2, "forced ack");
    // test 3 sends a single segment and then idles
    base = hdr_cnt;
    send_seg(ref_ack, rand_pld());
    wait_headers(base + 1, timeout + 60);
    d = sof_cyc - eof_cyc;
    assert ((d >= timeout) && (d <= timeout + 30)) else begin
      $display("Mismatch at %0t: timeout ack after %0d cycles", $time, d);
      errs++;
    end
    ack_seen();
    test_done(3, "timeout ack");
    // test 4 crosses the 32-bit wrap and then retransmits old data
    base = hdr_cnt;
    a0 = 32'hffffffb0;
    @(posedge clk) begin
      tcb.loc_ack <= a0;
      init <= 1'b1;
    end
    @(posedge clk) init <= 1'b0;
    repeat (2) @(posedge clk);
    for (int i = 1; i <= 3; i++) begin
      send_seg(ref_ack, 40);
      check_ack(a0 + 32'(40 * i)); // ends at 0x28 after the wrap
    end
    send_seg(32'hffffffd8, 40);
    check_ack(32'h00000028);
    wait_headers(base + 1, timeout + 60);
    ack_seen();
    test_done(4, "wraparound");
    // test 5 checks that header fields follow the tcb seen at the snapshot
    base = hdr_cnt;
    @(posedge clk) begin
      tcb.loc_port <= 16'($random(seed));
      tcb.rem_port <= 16'($random(seed));
      tcb.loc_seq  <= 32'($random(seed));
      tcb.win      <= 16'($random(seed));
    end
    send_seg(ref_ack, rand_pld());
    n = 0;
    while ((sof_cnt == base + 0) && (n < timeout + 60)) begin
      @(posedge clk);
      n++;
    end
    tcb.loc_seq <= ~tcb.loc_seq; // changes mid header must not leak in
    tcb.win     <= ~tcb.win;
    wait_headers(base + 1, 40);
    ack_seen();
    test_done(5, "header content");
    // test 6 owes nothing and sends nothing
    base = hdr_cnt;
    repeat (2 * timeout) @(posedge clk);
    assert (hdr_cnt == base) else begin
      $display("ack header sent while loc_ack was already acked");
      errs++;
    end
    test_done(6, "acked quiet");
    $display("tests 6, headers %0d, errors %0d", hdr_cnt, errs);
    if (errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* verification/tcp_ack_sva.sv */
module tcp_ack_sva (
  input logic                  clk,
  input logic                  rst,
  input logic                  tx_val,
  input logic                  tx_sof,
  input logic                  tx_eof,
  input logic                  init,
  input logic                  meta_val,
  input tcp_ack_pkg::tcp_num_t loc_ack
);

  ////////////////////////////////////////////////////////////
  // header framing
  ////////////////////////////////////////////////////////////

  // sof then eof 19 cycles later
  a_frame_len: assert property (@(posedge clk) disable iff (rst)
    tx_sof |-> ##19 tx_eof)
    else $error("header eof not 19 cycles after sof");

  // no gap and no second sof inside a header
  a_frame_cont: assert property (@(posedge clk) disable iff (rst)
    (tx_val && !tx_eof) |=> (tx_val && !tx_sof))
    else $error("header stream broken before eof");

  // transmitter held idle by reset
  a_rst_quiet: assert property (@(posedge clk)
    rst |=> !tx_val)
    else $error("tx_val high right after a reset cycle");

  ////////////////////////////////////////////////////////////
  // ack number source
  ////////////////////////////////////////////////////////////

  a_ack_src: assert property (@(posedge clk) disable iff (rst)
    $changed(loc_ack) |-> ($past(init) || $past(meta_val) || $past(rst)))
    else $error("loc_ack moved without init or a segment end");

endmodule

bind tcp_ack_top tcp_ack_sva u_sva (
  .clk      (clk),
  .rst      (rst),
  .tx_val   (tx_val),
  .tx_sof   (tx_sof),
  .tx_eof   (tx_eof),
  .init     (init),
  .meta_val (rx_meta.val),
  .loc_ack  (loc_ack)
);

/* src/tcp_ack_top.sv */
module tcp_ack_top (
  input  logic                  clk,
  input  logic                  rst,
  // incoming segment bytes
  input  logic [7:0]            rx_byte,
  input  logic                  rx_val,
  input  logic                  rx_sof,
  input  logic                  rx_eof,
  input  logic [15:0]           rx_len,
  // connection
  input  tcp_ack_pkg::tcb_t     tcb,
  input  logic                  init,
  input  tcp_ack_pkg::tcp_stat_t status,
  output tcp_ack_pkg::tcp_num_t loc_ack,
  // pure ack header out
  output logic [7:0]            tx_byte,
  output logic                  tx_val,
  output logic                  tx_sof,
  output logic                  tx_eof
);

  import tcp_ack_pkg::*;

  tcp_rx_meta_t rx_meta;   // parser to controller
  logic         seg_start;
  logic         send;      // controller to tx, level
  logic         sent;      // tx back to controller, pulse

  ////////////////////////////////////////////////////////////
  // rx parse, ack decision, header tx
  ////////////////////////////////////////////////////////////

  tcp_rx_parser u_parser (
    .clk       (clk),
    .rst       (rst),
    .rx_byte   (rx_byte),
    .rx_val    (rx_val),
    .rx_sof    (rx_sof),
    .rx_eof    (rx_eof),
    .rx_len    (rx_len),
    .rx_meta   (rx_meta),
    .seg_start (seg_start)
  );

  tcp_ack_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .rx_meta   (rx_meta),
    .seg_start (seg_start),
    .status    (status),
    .tcb       (tcb),
    .init      (init),
    .loc_ack   (loc_ack),
    .send      (send),
    .sent      (sent)
  );

  tcp_ack_tx u_tx (
    .clk       (clk),
    .rst       (rst),
    .tcb       (tcb),
    .loc_ack   (loc_ack),
    .send      (send),
    .sent      (sent),
    .tx_byte   (tx_byte),
    .tx_val    (tx_val),
    .tx_sof    (tx_sof),
    .tx_eof    (tx_eof)
  );

endmodule

/* tcp_ack/tcp_ack_tx.sv */
`include "tcp_ack_config.svh"

module tcp_ack_tx (
  input  logic                  clk,
  input  logic                  rst,
  input  tcp_ack_pkg::tcb_t     tcb,
  input  tcp_ack_pkg::tcp_num_t loc_ack,
  input  logic                  send,
  output logic                  sent,
  output logic [7:0]            tx_byte,
  output logic                  tx_val,
  output logic                  tx_sof,
  output logic                  tx_eof
);

  import tcp_ack_pkg::*;

  localparam int hdr_bytes = `TCP_HDR_BYTES;
  localparam int hdr_w = hdr_bytes * 8;
  localparam int idx_w = $clog2(hdr_bytes);

  tcp_ctl_word_u    ctl;      // offset, flags, window for this ack
  logic [hdr_w-1:0] hdr_sr;   // header snapshot, msb byte goes first
  logic [idx_w-1:0] idx;      // byte now on tx_byte
  logic             busy;
  logic             start;
  logic             last;

  ////////////////////////////////////////////////////////////
  // control word, built through the field view
  ////////////////////////////////////////////////////////////

  always_comb begin
    ctl.fld.data_ofs = 4'd5;  // no options
    ctl.fld.rsvd     = 3'd0;
    ctl.fld.flags    = 9'd0;
    ctl.fld.flags[tcp_flag_ack] = 1'b1; // pure ack
    ctl.fld.win      = tcb.win;
  end

  assign start = send && !busy;
  assign last  = (idx == idx_w'(hdr_bytes - 1));

  ////////////////////////////////////////////////////////////
  // sequencing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      idx  <= '0;
    end else if (start) begin
      busy <= 1'b1;
      idx  <= '0;
    end else if (busy) begin
      busy <= !last; // idle again after byte 20
      idx  <= idx + 1'b1;
    end
  end

  // snapshot on start, then shift a byte out per cycle
  always_ff @(posedge clk) begin
    if (start) begin
      hdr_sr <= {tcb.loc_port, tcb.rem_port, tcb.loc_seq, loc_ack,
                 ctl.raw, 16'h0000, 16'h0000}; // checksum, urgent
    end else if (busy) begin
      hdr_sr <= {hdr_sr[hdr_w-9:0], 8'h00};
    end
  end

  ////////////////////////////////////////////////////////////
  // byte stream
  ////////////////////////////////////////////////////////////

  assign tx_byte = hdr_sr[hdr_w-1 -: 8];
  assign tx_val  = busy;
  assign tx_sof  = busy && (idx == '0);
  assign tx_eof  = busy && last;
  assign sent    = tx_eof; // tells the controller to drop send

endmodule

/* tcp_ack/tcp_ack_ctrl.sv */
`include "tcp_ack_config.svh"

module tcp_ack_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  tcp_ack_pkg::tcp_rx_meta_t rx_meta,
  input  logic                      seg_start,
  input  tcp_ack_pkg::tcp_stat_t    status,
  input  tcp_ack_pkg::tcb_t         tcb,
  input  logic                      init,
  output tcp_ack_pkg::tcp_num_t     loc_ack,
  output logic                      send,
  input  logic                      sent
);

  import tcp_ack_pkg::*;

  localparam int timeout = `TCP_ACK_TIMEOUT;
  localparam int force_pkts = `TCP_ACK_FORCE_PKTS;
  localparam int tmr_w = $clog2(timeout + 1);
  localparam int cnt_w = $clog2(force_pkts + 1);

  tcp_num_t   seg_end;     // first sequence number past the segment
  tcp_num_t   diff;        // seg_end - loc_ack, mod 2^32
  logic       ahead;       // seg_end is newer than loc_ack
  logic       connected;
  logic       acked;       // peer already has loc_ack, nothing owed
  logic [tmr_w-1:0] timer;
  logic [cnt_w-1:0] unacked;
  logic       timeout_ack;
  logic       pkts_ack;

  ////////////////////////////////////////////////////////////
  // local ack number
  ////////////////////////////////////////////////////////////

  assign seg_end = rx_meta.seq + {16'd0, rx_meta.pld_len};
  assign diff    = seg_end - loc_ack;
  // serial order: nonzero distance less than half the space
  assign ahead   = (diff != '0) && !diff[31];

  always_ff @(posedge clk) begin
    if (rst) begin
      loc_ack <= '0;
    end else if (init) begin
      loc_ack <= tcb.loc_ack;                 // start from the tcb
    end else if (rx_meta.val && ahead) begin
      loc_ack <= seg_end;                     // older or repeated data leaves it alone
    end
  end

  assign connected = (status == tcp_connected);
  assign acked     = connected && (loc_ack == tcb.loc_ack);

  ////////////////////////////////////////////////////////////
  // unacked segment counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      unacked <= '0;
    end else if (!connected || acked || send) begin
      unacked <= '0; // nothing owed, or an ack is already on its way
    end else if (seg_start && !pkts_ack) begin
      unacked <= unacked + 1'b1; // holds at the limit
    end
  end

  assign pkts_ack = (unacked == cnt_w'(force_pkts));

  ////////////////////////////////////////////////////////////
  // ack timer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      timer <= '0;
    end else if (!connected || acked) begin
      timer <= '0;
    end else if (rx_meta.val && (seg_end != loc_ack)) begin
      timer <= '0;                                   // fresh data, wait again
    end else if (timer != tmr_w'(timeout)) begin
      timer <= timer + 1'b1;                         // parks at timeout
    end
  end

  // fires once per idle period, the parked value does not match
  assign timeout_ack = (timer == tmr_w'(timeout - 1));

  ////////////////////////////////////////////////////////////
  // send request
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      send <= 1'b0;
    end else if (timeout_ack || pkts_ack) begin
      send <= 1'b1;
    end else if (sent) begin
      send <= 1'b0; // drop the level once the header is out
    end
  end

endmodule

/* src/tcp_rx_parser.sv */
module tcp_rx_parser (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [7:0]                 rx_byte,
  input  logic                       rx_val,
  input  logic                       rx_sof,
  input  logic                       rx_eof,
  input  logic [15:0]                rx_len,
  output tcp_ack_pkg::tcp_rx_meta_t  rx_meta,
  output logic                       seg_start
);

  import tcp_ack_pkg::*;

  logic [4:0]    cnt;      // index of the next byte, saturates at 31
  logic [4:0]    idx;      // index of the byte on rx_byte now
  tcp_num_t      seq_sr;   // bytes 4..7 shift in here
  tcp_ctl_word_u ctl_sr;   // bytes 12..15 shift in here
  logic [15:0]   len_lat;  // segment length, captured with sof
  logic [15:0]   hdr_len;  // data offset in bytes

  logic          meta_val;
  tcp_num_t      meta_seq;
  logic [15:0]   meta_len;

  ////////////////////////////////////////////////////////////
  // byte position
  ////////////////////////////////////////////////////////////

  // sof always restarts at byte 0, even if the last segment was cut short
  assign idx = rx_sof ? 5'd0 : cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= 5'd0;
    end else if (rx_val && (idx != 5'h1f)) begin
      cnt <= idx + 5'd1; // stops at 31, only bytes below 16 matter
    end
  end

  ////////////////////////////////////////////////////////////
  // header field capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rx_val) begin
      if (rx_sof) len_lat <= rx_len;
      // sequence number, network order so msb first
      if ((idx >= 5'd4) && (idx <= 5'd7)) begin
        seq_sr <= {seq_sr[23:0], rx_byte};
      end
      // offset, flags and window as one raw word
      if ((idx >= 5'd12) && (idx <= 5'd15)) begin
        ctl_sr.raw <= {ctl_sr.raw[23:0], rx_byte};
      end
    end
  end

  // data offset counts 32-bit words
  assign hdr_len = {10'd0, ctl_sr.fld.data_ofs, 2'b00};

  ////////////////////////////////////////////////////////////
  // metadata out
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      meta_val  <= 1'b0;
      seg_start <= 1'b0;
    end else begin
      meta_val  <= rx_val & rx_eof; // one cycle after the last byte
      seg_start <= rx_val & rx_sof; // one cycle after the first byte
    end
  end

  // segments are at least 20 bytes so bytes 4..15 are in by eof
  always_ff @(posedge clk) begin
    if (rx_val && rx_eof) begin
      meta_seq <= seq_sr;
      meta_len <= len_lat - hdr_len; // payload only
    end
  end

  assign rx_meta = '{val: meta_val, seq: meta_seq, pld_len: meta_len};

endmodule

/* common/tcp_ack_pkg.sv */
package tcp_ack_pkg;

  //////////////////////////////////////////////////////////
  // basic header field types
  //////////////////////////////////////////////////////////

  typedef logic [31:0] tcp_num_t;  // sequence or ack number
  typedef logic [15:0] tcp_port_t; // tcp port
  typedef logic [15:0] tcp_win_t;  // advertised window

  // flag bit positions inside the 9-bit flags field
  // ns cwr ece urg ack psh rst syn fin, ns is the msb
  localparam int tcp_flag_ack = 4;

  //////////////////////////////////////////////////////////
  // header bytes 12..15
  //////////////////////////////////////////////////////////

  typedef struct packed {
    logic [3:0] data_ofs; // header length in 32-bit words
    logic [2:0] rsvd;     // always zero on transmit
    logic [8:0] flags;    // ns..fin
    tcp_win_t   win;      // window
  } tcp_ctl_fields_t;

  // same 32 bits seen as a byte-shifted word or as decoded fields
  // the parser fills it through raw, the transmitter builds it through fld
  typedef union packed {
    logic [31:0]     raw;
    tcp_ctl_fields_t fld;
  } tcp_ctl_word_u;

  //////////////////////////////////////////////////////////
  // per-segment metadata from the parser
  //////////////////////////////////////////////////////////

  typedef struct packed {
    logic        val;     // one-cycle pulse per segment
    tcp_num_t    seq;     // remote sequence number of the segment
    logic [15:0] pld_len; // payload bytes, header excluded
  } tcp_rx_meta_t;

  //////////////////////////////////////////////////////////
  // connection control block
  //////////////////////////////////////////////////////////

  typedef struct packed {
    tcp_port_t loc_port; // our port
    tcp_port_t rem_port; // peer port
    tcp_num_t  loc_seq;  // next local sequence number
    tcp_num_t  loc_ack;  // last ack the peer has seen from us
    tcp_win_t  win;      // window to advertise
  } tcb_t;

  // connection status, driven from outside as a level
  typedef enum logic {
    tcp_closed,
    tcp_connected
  } tcp_stat_t;

endpackage

/* common/tcp_ack_config.svh */
`ifndef TCP_ACK_CONFIG_SVH
`define TCP_ACK_CONFIG_SVH

//////////////////////////////////////////////////////////
// ack policy
//////////////////////////////////////////////////////////

// idle cycles after the last unacked segment before a pure ack goes out
`define TCP_ACK_TIMEOUT 1250

// unacked segments that force an ack without waiting for the timer
`define TCP_ACK_FORCE_PKTS 5

//////////////////////////////////////////////////////////
// header format
//////////////////////////////////////////////////////////

// bytes in a tcp header without options
`define TCP_HDR_BYTES 20

`endif
